// File: src/crc32.sv
`timescale 1ns/1ps

module crc32
    import crc_pkg::*;
(
    input  logic [DATA_WIDTH-1:0] i_data,
    input  logic [CRC_WIDTH-1:0]  i_crc_state,
    input  logic [DATA_BYTES-1:0] i_data_valid,

    output logic [CRC_WIDTH-1:0]  o_crc,
    output logic [CRC_WIDTH-1:0]  o_crc_state
);

    logic [LUT_DEPTH*CRC_WIDTH-1:0] lut [DATA_BYTES];     // Slicing tables, level 0..3

    for (genvar g = 0; g < DATA_BYTES; g++) begin : g_lut
        assign lut[g] = crc_table(g);                    // Folded to constants
    end

    logic [7:0]           table_index [DATA_BYTES];
    logic [CRC_WIDTH-1:0] lookup      [DATA_BYTES][DATA_BYTES];    // [level][byte]

    always_comb begin
        for (int b = 0; b < DATA_BYTES; b++) begin
            table_index[b] = i_crc_state[8*b +: 8] ^ i_data[8*b +: 8];
            for (int l = 0; l < DATA_BYTES; l++) begin
                lookup[l][b] = lut[l][table_index[b]*CRC_WIDTH +: CRC_WIDTH];
            end
        end
    end

    // The first byte on the wire needs the deepest table, since the most
    // bytes follow it inside the word
    logic [CRC_WIDTH-1:0] crc_calc [DATA_BYTES];

    always_comb begin
        crc_calc[0] = lookup[0][0];
        crc_calc[1] = lookup[0][1] ^ lookup[1][0];
        crc_calc[2] = lookup[0][2] ^ lookup[1][1] ^ lookup[2][0];
        crc_calc[3] = lookup[0][3] ^ lookup[1][2] ^ lookup[2][1] ^ lookup[3][0];
    end

    logic [CRC_WIDTH-1:0] crc_next;

    always_comb begin
        case (i_data_valid)
            4'b0001: crc_next = crc_calc[0] ^ (i_crc_state >> 8);    // Unused state bytes shift down
            4'b0011: crc_next = crc_calc[1] ^ (i_crc_state >> 16);
            4'b0111: crc_next = crc_calc[2] ^ (i_crc_state >> 24);
            default: crc_next = crc_calc[3];             // Full word
        endcase
    end

    assign o_crc_state = crc_next;
    assign o_crc       = ~crc_next;                      // Final inversion

    // Byte enables come from the accumulator, which only forwards keep on
    // valid beats; anything else means a broken tail code upstream
    always_comb begin
        assert final ($isunknown(i_data_valid) ||
                      (i_data_valid inside {4'b0001, 4'b0011, 4'b0111, 4'b1111}))
            else $error("crc32: illegal byte enable %b", i_data_valid);
    end

endmodule

// File: src/crc_accum.sv
`timescale 1ns/1ps

module crc_accum
    import crc_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    input  logic                  i_valid,
    input  logic                  i_sof,
    input  logic                  i_eof,
    input  logic [DATA_BYTES-1:0] i_keep,
    input  logic [DATA_WIDTH-1:0] i_data,

    output logic                  o_done,
    output logic [CRC_WIDTH-1:0]  o_crc,
    output logic                  o_match
);

    logic [CRC_WIDTH-1:0]  crc_q;                        // Running state between beats
    logic                  in_frame_q;

    logic                  beat_ok;
    logic [CRC_WIDTH-1:0]  step_state;
    logic [DATA_BYTES-1:0] step_keep;
    logic [CRC_WIDTH-1:0]  step_next;
    logic [CRC_WIDTH-1:0]  step_crc;

    // A sof beat always counts and restarts; other beats need an open frame
    assign beat_ok    = i_valid && (i_sof || in_frame_q);
    assign step_state = i_sof ? CRC_INIT : crc_q;
    assign step_keep  = i_valid ? i_keep : {DATA_BYTES{1'b1}};    // Idle cycles see a full word

    crc32 u_crc32 (
        .i_data       (i_data),
        .i_crc_state  (step_state),
        .i_data_valid (step_keep),
        .o_crc        (step_crc),
        .o_crc_state  (step_next)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            in_frame_q <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_done <= beat_ok && i_eof;                  // One cycle after the eof beat
            if (beat_ok) begin
                in_frame_q <= !i_eof;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (beat_ok) begin
            crc_q <= step_next;
        end
        if (beat_ok && i_eof) begin
            o_crc   <= step_crc;                         // Held until the next done
            o_match <= (step_next == CRC_RESIDUE);
        end
    end

    // Only the last beat may carry a partial word
    a_keep_full: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_valid && !i_eof) |-> (i_keep == {DATA_BYTES{1'b1}})
    ) else $error("crc_accum: partial keep %b on a non-eof beat", i_keep);

    // Two done strobes in a row are only possible when the second frame
    // was a single sof+eof beat right after the first eof
    a_done_pair: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_done && $past(o_done)) |-> $past(i_valid && i_sof && i_eof)
    ) else $error("crc_accum: back-to-back done without a one-beat frame");

endmodule

// File: src/crc_pkg.sv
package crc_pkg;

    localparam int CRC_WIDTH  = 32;
    localparam int DATA_WIDTH = 32;
    localparam int DATA_BYTES = DATA_WIDTH / 8;
    localparam int STAT_WIDTH = 16;
    localparam int LUT_DEPTH  = 256;                     // One entry per byte value

    localparam logic [CRC_WIDTH-1:0] CRC_POLY_REFL = 32'hEDB88320;    // Bit-reversed 0x04C11DB7
    localparam logic [CRC_WIDTH-1:0] CRC_INIT      = 32'hFFFFFFFF;
    localparam logic [CRC_WIDTH-1:0] CRC_RESIDUE   = 32'hDEBB20E3;    // Magic value after good FCS

    // Builds one slicing table, packed with entry i at bits [i*32 +: 32].
    // Level 0 is the classic byte-at-a-time table. Level n gives the effect
    // of a byte followed by n zero bytes, which is what lets four bytes be
    // folded in one step.
    function automatic logic [LUT_DEPTH*CRC_WIDTH-1:0] crc_table(input int level);
        logic [CRC_WIDTH-1:0]           base [LUT_DEPTH];
        logic [CRC_WIDTH-1:0]           entry;
        logic [LUT_DEPTH*CRC_WIDTH-1:0] tbl;

        for (int i = 0; i < LUT_DEPTH; i++) begin
            entry = CRC_WIDTH'(i);
            for (int b = 0; b < 8; b++) begin
                if (entry[0]) begin
                    entry = (entry >> 1) ^ CRC_POLY_REFL;
                end else begin
                    entry = entry >> 1;
                end
            end
            base[i] = entry;                             // Level 0 table
        end

        for (int i = 0; i < LUT_DEPTH; i++) begin
            entry = base[i];
            for (int l = 0; l < level; l++) begin
                entry = (entry >> 8) ^ base[entry[7:0]]; // Advance by one zero byte
            end
            tbl[i*CRC_WIDTH +: CRC_WIDTH] = entry;
        end

        return tbl;
    endfunction

endpackage

// File: src/eth_crc_top.sv
`timescale 1ns/1ps

module eth_crc_top
    import crc_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Transmit beats
    input  logic                  i_tx_valid,
    input  logic                  i_tx_sof,
    input  logic                  i_tx_eof,
    input  logic [DATA_BYTES-1:0] i_tx_keep,
    input  logic [DATA_WIDTH-1:0] i_tx_data,

    output logic                  o_tx_fcs_valid,
    output logic [CRC_WIDTH-1:0]  o_tx_fcs,

    // Receive beats, FCS included at the tail
    input  logic                  i_rx_valid,
    input  logic                  i_rx_sof,
    input  logic                  i_rx_eof,
    input  logic [DATA_BYTES-1:0] i_rx_keep,
    input  logic [DATA_WIDTH-1:0] i_rx_data,

    output logic                  o_rx_done,
    output logic                  o_rx_ok,
    output logic [STAT_WIDTH-1:0] o_rx_good_cnt,
    output logic [STAT_WIDTH-1:0] o_rx_bad_cnt
);

    crc_accum u_tx_accum (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_tx_valid),
        .i_sof   (i_tx_sof),
        .i_eof   (i_tx_eof),
        .i_keep  (i_tx_keep),
        .i_data  (i_tx_data),
        .o_done  (o_tx_fcs_valid),
        .o_crc   (o_tx_fcs),
        .o_match ()                                      // Residue check unused on transmit
    );

    crc_accum u_rx_accum (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_rx_valid),
        .i_sof   (i_rx_sof),
        .i_eof   (i_rx_eof),
        .i_keep  (i_rx_keep),
        .i_data  (i_rx_data),
        .o_done  (o_rx_done),
        .o_crc   (),
        .o_match (o_rx_ok)
    );

    // Counters trail o_rx_done by one cycle
    fcs_stats u_stats (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_done     (o_rx_done),
        .i_match    (o_rx_ok),
        .o_good_cnt (o_rx_good_cnt),
        .o_bad_cnt  (o_rx_bad_cnt)
    );

endmodule

// File: src/fcs_stats.sv
`timescale 1ns/1ps

module fcs_stats
    import crc_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    input  logic                  i_done,
    input  logic                  i_match,

    output logic [STAT_WIDTH-1:0] o_good_cnt,
    output logic [STAT_WIDTH-1:0] o_bad_cnt
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_good_cnt <= '0;
            o_bad_cnt  <= '0;
        end else if (i_done) begin
            if (i_match) begin
                o_good_cnt <= o_good_cnt + 1'b1;         // Wraps on overflow
            end else begin
                o_bad_cnt  <= o_bad_cnt + 1'b1;
            end
        end
    end

    // Each frame lands in exactly one bucket
    a_one_bucket: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !($changed(o_good_cnt) && $changed(o_bad_cnt))
    ) else $error("fcs_stats: good and bad counters moved together");

endmodule

// File: tb.f
+incdir+verif
src/crc_pkg.sv
src/crc32.sv
src/crc_accum.sv
src/fcs_stats.sv
src/eth_crc_top.sv
verif/tb_eth_crc.sv

// File: verif/crc_ref_tasks.svh
`ifndef CRC_REF_TASKS_SVH
`define CRC_REF_TASKS_SVH

localparam logic [31:0] REF_POLY = 32'hEDB88320;         // Reflected CRC-32 polynomial
localparam logic [31:0] REF_INIT = 32'hFFFFFFFF;

typedef logic [7:0] byte_q_t [$];

// Bit-serial CRC-32 over a byte queue, first byte on the wire first
function automatic logic [31:0] crc_ref(input byte_q_t q);
    logic [31:0] crc;

    crc = REF_INIT;
    foreach (q[i]) begin
        crc = crc ^ {24'h0, q[i]};
        for (int b = 0; b < 8; b++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ REF_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
    end
    return ~crc;                                         // Final inversion
endfunction

// Drives one beat on the next rising edge
task automatic drive_beat(input bit rx, input logic sof, input logic eof,
                          input logic [DATA_BYTES-1:0] keep,
                          input logic [DATA_WIDTH-1:0] data);
    @(posedge clk);
    if (rx) begin
        rx_valid <= 1'b1;
        rx_sof   <= sof;
        rx_eof   <= eof;
        rx_keep  <= keep;
        rx_data  <= data;
    end else begin
        tx_valid <= 1'b1;
        tx_sof   <= sof;
        tx_eof   <= eof;
        tx_keep  <= keep;
        tx_data  <= data;
    end
endtask

task automatic idle_cycles(input bit rx, input int n);
    repeat (n) begin
        @(posedge clk);
        if (rx) begin
            rx_valid <= 1'b0;
            rx_sof   <= 1'b0;
            rx_eof   <= 1'b0;
        end else begin
            tx_valid <= 1'b0;
            tx_sof   <= 1'b0;
            tx_eof   <= 1'b0;
        end
    end
endtask

// Splits a byte queue into beats, byte 0 in data[7:0]
task automatic drive_frame(input bit rx, input byte_q_t q, input int max_gap,
                           input bit close);
    int                    n_beats;
    int                    idx;
    logic [DATA_WIDTH-1:0] data;
    logic [DATA_BYTES-1:0] keep;

    n_beats = (q.size() + DATA_BYTES - 1) / DATA_BYTES;
    for (int b = 0; b < n_beats; b++) begin
        data = '0;
        keep = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            idx = b * DATA_BYTES + i;
            if (idx < q.size()) begin
                data[8*i +: 8] = q[idx];
                keep[i]        = 1'b1;
            end
        end
        if (b > 0 && max_gap > 0) begin
            idle_cycles(rx, $urandom_range(max_gap));    // Random idle between beats
        end
        drive_beat(rx, b == 0, b == n_beats - 1, keep, data);
    end
    if (close) begin
        idle_cycles(rx, 1);
    end
endtask

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("mismatch %s (%s): expected 0x%08h actual 0x%08h",
                 cur_test, what, expected, actual);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

`endif

// File: verif/tb_eth_crc.sv
`timescale 1ns/1ps

module tb_eth_crc
    import crc_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int STROBE_LIMIT = 8;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_FRAMES  = 1 + 16 + 8 + 8 + 8 + 5;    // Frames over all six tests
    localparam int WATCHDOG_CYCLES = TEST_FRAMES * 40 + NUM_TESTS * 200;

    logic clk   = 1'b0;
    logic rst_n = 1'b0;

    logic                  tx_valid = 1'b0;
    logic                  tx_sof   = 1'b0;
    logic                  tx_eof   = 1'b0;
    logic [DATA_BYTES-1:0] tx_keep  = '1;
    logic [DATA_WIDTH-1:0] tx_data  = '0;
    logic                  rx_valid = 1'b0;
    logic                  rx_sof   = 1'b0;
    logic                  rx_eof   = 1'b0;
    logic [DATA_BYTES-1:0] rx_keep  = '1;
    logic [DATA_WIDTH-1:0] rx_data  = '0;

    logic                  o_tx_fcs_valid;
    logic [CRC_WIDTH-1:0]  o_tx_fcs;
    logic                  o_rx_done;
    logic                  o_rx_ok;
    logic [STAT_WIDTH-1:0] o_rx_good_cnt;
    logic [STAT_WIDTH-1:0] o_rx_bad_cnt;

    string cur_test;
    int    pass_count = 0;
    int    fail_count = 0;
    int    test_fail_base;

    logic [CRC_WIDTH-1:0] tx_results [$];               // One entry per done strobe
    logic                 rx_results [$];

    `include "crc_ref_tasks.svh"

    eth_crc_top uut (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_tx_valid     (tx_valid),
        .i_tx_sof       (tx_sof),
        .i_tx_eof       (tx_eof),
        .i_tx_keep      (tx_keep),
        .i_tx_data      (tx_data),
        .o_tx_fcs_valid (o_tx_fcs_valid),
        .o_tx_fcs       (o_tx_fcs),
        .i_rx_valid     (rx_valid),
        .i_rx_sof       (rx_sof),
        .i_rx_eof       (rx_eof),
        .i_rx_keep      (rx_keep),
        .i_rx_data      (rx_data),
        .o_rx_done      (o_rx_done),
        .o_rx_ok        (o_rx_ok),
        .o_rx_good_cnt  (o_rx_good_cnt),
        .o_rx_bad_cnt   (o_rx_bad_cnt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Mid-cycle capture keeps back-to-back strobes apart
    always @(negedge clk) begin
        if (o_tx_fcs_valid) tx_results.push_back(o_tx_fcs);
        if (o_rx_done) rx_results.push_back(o_rx_ok);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    task automatic fill_random(output byte_q_t q, input int len);
        q = {};
        repeat (len) q.push_back(8'($urandom));
    endtask

    // Payload with its FCS appended least significant byte first
    task automatic build_rx_frame(output byte_q_t q, input int payload_len);
        logic [31:0] fcs;

        fill_random(q, payload_len);
        fcs = crc_ref(q);
        for (int i = 0; i < 4; i++) q.push_back(fcs[8*i +: 8]);
    endtask

    task automatic wait_results(input bit rx, input int count, output bit got);
        int waited;

        waited = 0;
        while ((rx ? rx_results.size() : tx_results.size()) < count
               && waited < STROBE_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        got = (rx ? rx_results.size() : tx_results.size()) >= count;
        if (!got) begin
            $display("%s: the %s path gave no done strobe within %0d cycles",
                     cur_test, rx ? "receive" : "transmit", STROBE_LIMIT);
            fail_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_fail_base = fail_count;
        tx_results.delete();
        rx_results.delete();
        @(negedge clk);
    endtask

    task automatic end_test();
        if (fail_count == test_fail_base) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d failed checks", cur_test, fail_count - test_fail_base);
        end
    endtask

    task automatic test_known_vector();
        byte_q_t q;

        begin_test("known_vector");
        for (int i = 0; i < 9; i++) q.push_back(8'h31 + 8'(i));    // ASCII 1 to 9
        drive_frame(0, q, 0, 1);
        @(negedge clk);                                  // One cycle after eof
        check_value("fcs valid", 1, o_tx_fcs_valid);
        check_value("fcs", 32'hCBF43926, o_tx_fcs);
        end_test();
    endtask

    task automatic test_tail_lengths();
        byte_q_t q;
        bit      got;

        begin_test("tail_lengths");
        for (int tail = 1; tail <= DATA_BYTES; tail++) begin
            for (int beats = 1; beats <= 4; beats++) begin
                fill_random(q, (beats - 1) * DATA_BYTES + tail);
                tx_results.delete();
                drive_frame(0, q, 3, 1);
                wait_results(0, 1, got);
                if (got) begin
                    check_value($sformatf("%0d beats tail %0d", beats, tail),
                                crc_ref(q), tx_results[0]);
                end
            end
        end
        end_test();
    endtask

    // Corrupted frames get one flipped bit anywhere, FCS included
    task automatic test_rx_frames(input string name, input bit corrupt);
        byte_q_t               q;
        bit                    got;
        int                    idx;
        logic [STAT_WIDTH-1:0] good0;
        logic [STAT_WIDTH-1:0] bad0;

        begin_test(name);
        repeat (8) begin
            build_rx_frame(q, $urandom_range(12, 1));
            if (corrupt) begin
                idx    = $urandom_range(q.size() - 1);
                q[idx] = q[idx] ^ (8'h01 << $urandom_range(7));
            end
            good0 = o_rx_good_cnt;
            bad0  = o_rx_bad_cnt;
            rx_results.delete();
            drive_frame(1, q, 2, 1);
            wait_results(1, 1, got);
            @(negedge clk);                              // Counters trail done by a cycle
            if (got) check_value("rx ok", !corrupt, rx_results[0]);
            check_value("good count", STAT_WIDTH'(good0 + !corrupt), o_rx_good_cnt);
            check_value("bad count", STAT_WIDTH'(bad0 + corrupt), o_rx_bad_cnt);
        end
        end_test();
    endtask

    task automatic test_back_to_back();
        byte_q_t               a;
        byte_q_t               b;
        byte_q_t               c;
        bit                    got;
        logic [STAT_WIDTH-1:0] good0;
        logic [STAT_WIDTH-1:0] bad0;

        begin_test("back_to_back");
        fill_random(a, 11);
        fill_random(b, 2);                               // One-beat frame in the middle
        fill_random(c, 7);
        drive_frame(0, a, 0, 0);
        drive_frame(0, b, 0, 0);
        drive_frame(0, c, 0, 1);
        wait_results(0, 3, got);
        if (got) begin
            check_value("frame a", crc_ref(a), tx_results[0]);
            check_value("frame b", crc_ref(b), tx_results[1]);
            check_value("frame c", crc_ref(c), tx_results[2]);
        end

        // Good then bad receive frame with no gap
        build_rx_frame(a, 5);
        build_rx_frame(b, 3);
        b[b.size() - 1] = b[b.size() - 1] ^ 8'h80;
        good0 = o_rx_good_cnt;
        bad0  = o_rx_bad_cnt;
        drive_frame(1, a, 0, 0);
        drive_frame(1, b, 0, 1);
        wait_results(1, 2, got);
        @(negedge clk);
        if (got) begin
            check_value("rx first ok", 1, rx_results[0]);
            check_value("rx second ok", 0, rx_results[1]);
        end
        check_value("good count", STAT_WIDTH'(good0 + 1), o_rx_good_cnt);
        check_value("bad count", STAT_WIDTH'(bad0 + 1), o_rx_bad_cnt);

        // Restart with sof inside an open frame
        tx_results.delete();
        drive_beat(0, 1, 0, '1, DATA_WIDTH'($urandom));
        drive_beat(0, 0, 0, '1, DATA_WIDTH'($urandom));
        fill_random(c, 9);
        drive_frame(0, c, 1, 1);
        wait_results(0, 1, got);
        if (got) check_value("restart", crc_ref(c), tx_results[0]);

        // Beats without sof outside a frame
        tx_results.delete();
        rx_results.delete();
        good0 = o_rx_good_cnt;
        bad0  = o_rx_bad_cnt;
        drive_beat(0, 0, 1, 4'b0011, DATA_WIDTH'($urandom));
        idle_cycles(0, 1);
        drive_beat(0, 0, 0, '1, DATA_WIDTH'($urandom));
        drive_beat(0, 0, 1, '1, DATA_WIDTH'($urandom));
        idle_cycles(0, 1);
        drive_beat(1, 0, 1, '1, DATA_WIDTH'($urandom));
        idle_cycles(1, 4);
        @(negedge clk);
        check_value("stray tx strobes", 0, tx_results.size());
        check_value("stray rx strobes", 0, rx_results.size());
        check_value("stray good count", good0, o_rx_good_cnt);
        check_value("stray bad count", bad0, o_rx_bad_cnt);
        fill_random(c, 6);
        drive_frame(0, c, 1, 1);
        wait_results(0, 1, got);
        if (got) check_value("after stray", crc_ref(c), tx_results[0]);
        end_test();
    endtask

    task automatic test_reset();
        byte_q_t q;
        bit      got;

        begin_test("reset");
        fill_random(q, 10);
        drive_frame(0, q, 1, 1);
        build_rx_frame(q, 7);
        drive_frame(1, q, 1, 1);
        wait_results(1, 1, got);

        // Open both paths, then reset on the same edge as their eof beats
        drive_beat(0, 1, 0, '1, DATA_WIDTH'($urandom));
        drive_beat(1, 1, 0, '1, DATA_WIDTH'($urandom));
        @(posedge clk);
        rst_n  <= 1'b0;
        tx_sof <= 1'b0;
        tx_eof <= 1'b1;
        rx_sof <= 1'b0;
        rx_eof <= 1'b1;
        idle_cycles(0, 1);
        rx_valid <= 1'b0;
        rx_eof   <= 1'b0;
        @(negedge clk);
        check_value("fcs valid in reset", 0, o_tx_fcs_valid);
        check_value("rx done in reset", 0, o_rx_done);
        check_value("good count in reset", 0, o_rx_good_cnt);
        check_value("bad count in reset", 0, o_rx_bad_cnt);
        @(posedge clk);
        rst_n <= 1'b1;                                   // Reset held for two cycles

        tx_results.delete();
        rx_results.delete();
        drive_beat(0, 0, 1, '1, DATA_WIDTH'($urandom));  // Frame state must be closed
        idle_cycles(0, 3);
        check_value("no done after reset", 0, tx_results.size());
        fill_random(q, 13);
        drive_frame(0, q, 2, 1);
        wait_results(0, 1, got);
        if (got) check_value("frame after reset", crc_ref(q), tx_results[0]);
        build_rx_frame(q, 9);
        drive_frame(1, q, 2, 1);
        wait_results(1, 1, got);
        @(negedge clk);
        check_value("good count after reset", 1, o_rx_good_cnt);
        check_value("bad count after reset", 0, o_rx_bad_cnt);
        end_test();
    endtask

    initial begin
        void'($urandom(92));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_known_vector();
        test_tail_lengths();
        test_rx_frames("rx_good", 1'b0);
        test_rx_frames("rx_corrupt", 1'b1);
        test_back_to_back();
        test_reset();

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
